//--- verilog/pam_pkg.sv
`default_nettype none

package pam_pkg;

	// ========================================
	// Command encoding
	// ========================================

	// Operation carried through the pipeline
	// Value 3 is never generated by the queue
	typedef enum logic [1:0]
	{
		OP_ALLOC   = 2'd0,
		OP_FREE    = 2'd1,
		OP_FREEALL = 2'd2
	} pam_op_e;

	// ========================================
	// Map geometry
	// ========================================

	// Page bits held in one map word
	localparam int PAM_WORD_BITS = 64;

	// Pages 0 to 2 are kept for the OS
	// The last page (system stack) is reserved as well
	localparam int PAM_RESERVED_LOW = 3;

	// ========================================
	// Defaults for the top level
	// ========================================

	// Width of a page number, 8192 pages
	localparam int PAM_DEF_PAGE_BITS = 13;

	// 4 KiB pages
	localparam int PAM_DEF_PAGE_SHIFT = 12;

	// Command queue entries
	localparam int PAM_DEF_QUEUE_DEPTH = 4;

endpackage

`default_nettype wire

//--- verilog/pam_cmd_if.sv
`timescale 1ns/1ps
`default_nettype none

// Queued command, queue to bitmap
interface pam_cmd_if #(
	parameter int PAGE_BITS = pam_pkg::PAM_DEF_PAGE_BITS
);
	import pam_pkg::*;

	// One-cycle issue strobe
	logic valid;
	// Operation and page number for a free
	pam_op_e op;
	logic [PAGE_BITS-1:0] pageno;
	// Bitmap working, from accept until completion
	logic busy;

	// Queue side
	modport source
	(
		output valid,
		output op,
		output pageno,
		input busy
	);

	// Bitmap side
	modport sink
	(
		input valid,
		input op,
		input pageno,
		output busy
	);

endinterface

`default_nettype wire

//--- verilog/pam_resp_if.sv
`timescale 1ns/1ps
`default_nettype none

// Completed command, bitmap to response stage
interface pam_resp_if #(
	parameter int PAGE_BITS = pam_pkg::PAM_DEF_PAGE_BITS
);
	import pam_pkg::*;

	// One-cycle completion strobe
	logic done;
	// Operation that finished
	pam_op_e op;
	// Allocated or freed page, 0 on failure
	logic [PAGE_BITS-1:0] pageno;
	// Low on refusal, exhaustion or the reset sweep
	logic ok;

	// Bitmap side
	modport source
	(
		output done,
		output op,
		output pageno,
		output ok
	);

	// Response stage side
	modport sink
	(
		input done,
		input op,
		input pageno,
		input ok
	);

endinterface

`default_nettype wire

//--- verilog/pam_cmd_queue.sv
`timescale 1ns/1ps
`default_nettype none

module pam_cmd_queue #(
	parameter int PAGE_BITS   = pam_pkg::PAM_DEF_PAGE_BITS,
	parameter int QUEUE_DEPTH = pam_pkg::PAM_DEF_QUEUE_DEPTH
)
(
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire logic                 alloc_i,
	input  wire logic                 free_i,
	input  wire logic                 freeall_i,
	input  wire logic [PAGE_BITS-1:0] pageno_i,
	output logic                      overflow_o,
	pam_cmd_if.source                 cmd
);
	import pam_pkg::*;

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	// FIFO storage
	pam_op_e              op_mem   [QUEUE_DEPTH];
	logic [PAGE_BITS-1:0] page_mem [QUEUE_DEPTH];

	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] count_q;

	pam_op_e              push_op;
	logic [PAGE_BITS-1:0] push_page;
	logic                 push_req;
	logic                 full;
	logic                 push;
	logic                 pop;

	// ========================================
	// Strobe encoding
	// ========================================

	// Priority freeall, free, alloc
	// Page number only matters for a free
	always_comb
	begin
		push_op = OP_ALLOC;
		push_page = '0;
		if (freeall_i)
			push_op = OP_FREEALL;
		else if (free_i)
		begin
			push_op = OP_FREE;
			push_page = pageno_i;
		end
	end

	assign push_req = alloc_i | free_i | freeall_i;
	assign full = (count_q == CNT_W'(QUEUE_DEPTH));
	// No room, command is lost
	assign push = push_req & ~full;
	// Issue only to an idle bitmap, and never two strobes back to back
	assign pop = (count_q != '0) & ~cmd.valid & ~cmd.busy;

	// ========================================
	// Storage and issue register
	// ========================================

	always_ff @(posedge clk)
	begin
		if (push)
		begin
			op_mem[wr_ptr_q] <= push_op;
			page_mem[wr_ptr_q] <= push_page;
		end
		if (pop)
		begin
			cmd.op <= op_mem[rd_ptr_q];
			cmd.pageno <= page_mem[rd_ptr_q];
		end
	end

	// Pointers, occupancy and flags
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
			cmd.valid <= 1'b0;
			overflow_o <= 1'b0;
		end
		else
		begin
			cmd.valid <= pop;
			if (push_req & full)
				overflow_o <= 1'b1;
			if (push)
				wr_ptr_q <= (wr_ptr_q == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
			if (pop)
				rd_ptr_q <= (rd_ptr_q == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
			case ({push, pop})
			2'b10: count_q <= count_q + 1'b1;
			2'b01: count_q <= count_q - 1'b1;
			default: count_q <= count_q;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/pam_bitmap.sv
`timescale 1ns/1ps
`default_nettype none

module pam_bitmap #(
	parameter int PAGE_BITS = pam_pkg::PAM_DEF_PAGE_BITS
)
(
	input  wire logic clk,
	input  wire logic rst,
	pam_cmd_if.sink   cmd,
	pam_resp_if.source resp
);
	import pam_pkg::*;

	localparam int BIT_SEL_BITS  = $clog2(PAM_WORD_BITS);
	localparam int WORD_SEL_BITS = PAGE_BITS - BIT_SEL_BITS;
	localparam int NUM_WORDS     = 2 ** WORD_SEL_BITS;
	localparam logic [WORD_SEL_BITS-1:0] LAST_WORD = WORD_SEL_BITS'(NUM_WORDS - 1);

	typedef enum logic [3:0]
	{
		ST_CLEAR,
		ST_IDLE,
		ST_ALLOC_RD,
		ST_ALLOC_SCAN,
		ST_ALLOC_SET,
		ST_ALLOC_WR,
		ST_FREE_RD,
		ST_FREE_MOD,
		ST_FREE_WR
	} state_e;

	// One bit per page, set means in use
	logic [PAM_WORD_BITS-1:0] map_mem [NUM_WORDS];

	state_e                   state;
	logic [WORD_SEL_BITS-1:0] wordno;
	logic [BIT_SEL_BITS-1:0]  bitno;
	logic [PAM_WORD_BITS-1:0] map_q;
	logic                     user_clear;
	logic                     free_ok;

	logic [PAM_WORD_BITS-1:0] rsv_mask;
	logic                     rsv_page;
	logic                     mem_we;
	logic [PAM_WORD_BITS-1:0] mem_wdata;

	// Lowest clear bit of a word, scanning down so the last hit wins
	function automatic logic [BIT_SEL_BITS-1:0] lowest_clear(input logic [PAM_WORD_BITS-1:0] w);
		logic [BIT_SEL_BITS-1:0] idx;
		idx = '0;
		for (int n = PAM_WORD_BITS - 1; n >= 0; n--)
			if (!w[n])
				idx = BIT_SEL_BITS'(n);
		return idx;
	endfunction

	// Reserved pages seen as taken during a scan
	always_comb
	begin
		rsv_mask = '0;
		if (wordno == '0)
			rsv_mask[PAM_RESERVED_LOW-1:0] = '1;
		if (wordno == LAST_WORD)
			rsv_mask[PAM_WORD_BITS-1] = 1'b1;
	end

	// Freeing pages 0..2 or the last page is refused
	assign rsv_page = ({wordno, bitno} < PAGE_BITS'(PAM_RESERVED_LOW))
		| (&{wordno, bitno});

	assign cmd.busy = (state != ST_IDLE);

	// ========================================
	// Map write port
	// ========================================

	always_comb
	begin
		mem_we = 1'b0;
		mem_wdata = map_q;
		case (state)
		ST_CLEAR:
		begin
			mem_we = 1'b1;
			mem_wdata = '0;
		end
		ST_ALLOC_WR,
		ST_FREE_WR:
			mem_we = 1'b1;
		default:
			mem_we = 1'b0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (mem_we)
			map_mem[wordno] <= mem_wdata;
	end

	// ========================================
	// Control FSM
	// ========================================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= ST_CLEAR;
			wordno <= '0;
			user_clear <= 1'b0;
			resp.done <= 1'b0;
		end
		else
		begin
			resp.done <= 1'b0;
			case (state)
			// One word per cycle, strobe after the last one
			ST_CLEAR:
			begin
				wordno <= wordno + 1'b1;
				if (wordno == LAST_WORD)
				begin
					resp.done <= 1'b1;
					resp.op <= OP_FREEALL;
					resp.pageno <= '0;
					// Low marks the reset sweep
					resp.ok <= user_clear;
					state <= ST_IDLE;
				end
			end
			ST_IDLE:
			begin
				if (cmd.valid)
				begin
					case (cmd.op)
					OP_FREEALL:
					begin
						wordno <= '0;
						user_clear <= 1'b1;
						state <= ST_CLEAR;
					end
					OP_FREE:
					begin
						wordno <= cmd.pageno[PAGE_BITS-1:BIT_SEL_BITS];
						bitno <= cmd.pageno[BIT_SEL_BITS-1:0];
						state <= ST_FREE_RD;
					end
					OP_ALLOC:
					begin
						wordno <= '0;
						state <= ST_ALLOC_RD;
					end
					default:
						state <= ST_IDLE;
					endcase
				end
			end
			ST_ALLOC_RD:
			begin
				map_q <= map_mem[wordno] | rsv_mask;
				state <= ST_ALLOC_SCAN;
			end
			ST_ALLOC_SCAN:
			begin
				if (&map_q)
				begin
					// Whole map taken
					if (wordno == LAST_WORD)
					begin
						resp.done <= 1'b1;
						resp.op <= OP_ALLOC;
						resp.pageno <= '0;
						resp.ok <= 1'b0;
						state <= ST_IDLE;
					end
					else
					begin
						wordno <= wordno + 1'b1;
						state <= ST_ALLOC_RD;
					end
				end
				else
				begin
					bitno <= lowest_clear(map_q);
					state <= ST_ALLOC_SET;
				end
			end
			ST_ALLOC_SET:
			begin
				map_q[bitno] <= 1'b1;
				state <= ST_ALLOC_WR;
			end
			// Word written back by the write port this cycle
			ST_ALLOC_WR:
			begin
				resp.done <= 1'b1;
				resp.op <= OP_ALLOC;
				resp.pageno <= {wordno, bitno};
				resp.ok <= 1'b1;
				state <= ST_IDLE;
			end
			ST_FREE_RD:
			begin
				map_q <= map_mem[wordno];
				state <= ST_FREE_MOD;
			end
			// Refused free leaves the word as read
			ST_FREE_MOD:
			begin
				free_ok <= ~rsv_page & map_q[bitno];
				if (!rsv_page)
					map_q[bitno] <= 1'b0;
				state <= ST_FREE_WR;
			end
			ST_FREE_WR:
			begin
				resp.done <= 1'b1;
				resp.op <= OP_FREE;
				resp.pageno <= {wordno, bitno};
				resp.ok <= free_ok;
				state <= ST_IDLE;
			end
			default:
				state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/pam_resp.sv
`timescale 1ns/1ps
`default_nettype none

module pam_resp #(
	parameter int PAGE_BITS  = pam_pkg::PAM_DEF_PAGE_BITS,
	parameter int PAGE_SHIFT = pam_pkg::PAM_DEF_PAGE_SHIFT
)
(
	input  wire logic                            clk,
	input  wire logic                            rst,
	pam_resp_if.sink                             resp,
	output logic                                 done_o,
	output logic                                 ok_o,
	output logic [PAGE_BITS-1:0]                 pageno_o,
	output logic [PAGE_BITS+PAGE_SHIFT-1:0]      addr_o,
	output logic [PAGE_BITS-1:0]                 free_count_o
);
	import pam_pkg::*;

	// Map words times bits per word
	localparam int TOTAL_PAGES = (2 ** (PAGE_BITS - $clog2(PAM_WORD_BITS))) * PAM_WORD_BITS;
	// Low reserved pages plus the last one
	localparam int MAX_FREE = TOTAL_PAGES - PAM_RESERVED_LOW - 1;

	logic sweep_done;

	// Reset sweep ends as a freeall with ok low, not reported outside
	assign sweep_done = resp.done & (resp.op == OP_FREEALL) & ~resp.ok;

	// ========================================
	// Result register
	// ========================================

	always_ff @(posedge clk)
	begin
		if (resp.done)
		begin
			pageno_o <= resp.pageno;
			// Page number to byte address
			addr_o <= {resp.pageno, {PAGE_SHIFT{1'b0}}};
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			done_o <= 1'b0;
			ok_o <= 1'b0;
			free_count_o <= '0;
		end
		else
		begin
			done_o <= resp.done & ~sweep_done;
			// ok only alongside done
			ok_o <= resp.done & resp.ok;
			if (resp.done)
			begin
				case (resp.op)
				OP_ALLOC:
					if (resp.ok)
						free_count_o <= free_count_o - PAGE_BITS'(1);
				OP_FREE:
					if (resp.ok)
						free_count_o <= free_count_o + PAGE_BITS'(1);
				// Clear, user or sweep
				OP_FREEALL:
					free_count_o <= PAGE_BITS'(MAX_FREE);
				default:
					free_count_o <= free_count_o;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/pam_top.sv
`timescale 1ns/1ps
`default_nettype none

module pam_top #(
	parameter int PAGE_BITS   = pam_pkg::PAM_DEF_PAGE_BITS,
	parameter int PAGE_SHIFT  = pam_pkg::PAM_DEF_PAGE_SHIFT,
	parameter int QUEUE_DEPTH = pam_pkg::PAM_DEF_QUEUE_DEPTH
)
(
	input  wire logic                              clk,
	input  wire logic                              rst,
	// Command strobes, at most one per cycle
	input  wire logic                              alloc_i,
	input  wire logic                              free_i,
	input  wire logic                              freeall_i,
	input  wire logic [PAGE_BITS-1:0]              pageno_i,
	// Results, in command order
	output logic                                   done_o,
	output logic                                   ok_o,
	output logic [PAGE_BITS-1:0]                   pageno_o,
	output logic [PAGE_BITS+PAGE_SHIFT-1:0]        addr_o,
	output logic [PAGE_BITS-1:0]                   free_count_o,
	// Sticky, a command was dropped
	output logic                                   overflow_o
);

	// ========================================
	// Stage links
	// ========================================

	pam_cmd_if #(.PAGE_BITS(PAGE_BITS)) cmd_if ();
	pam_resp_if #(.PAGE_BITS(PAGE_BITS)) resp_if ();

	// ========================================
	// Pipeline
	// ========================================

	// Stage 1, strobes into the command FIFO
	pam_cmd_queue #(
		.PAGE_BITS(PAGE_BITS),
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) u_queue (
		.clk(clk),
		.rst(rst),
		.alloc_i(alloc_i),
		.free_i(free_i),
		.freeall_i(freeall_i),
		.pageno_i(pageno_i),
		.overflow_o(overflow_o),
		.cmd(cmd_if.source)
	);

	// Stage 2, allocation map
	pam_bitmap #(
		.PAGE_BITS(PAGE_BITS)
	) u_bitmap (
		.clk(clk),
		.rst(rst),
		.cmd(cmd_if.sink),
		.resp(resp_if.source)
	);

	// Stage 3, result register and free count
	pam_resp #(
		.PAGE_BITS(PAGE_BITS),
		.PAGE_SHIFT(PAGE_SHIFT)
	) u_resp (
		.clk(clk),
		.rst(rst),
		.resp(resp_if.sink),
		.done_o(done_o),
		.ok_o(ok_o),
		.pageno_o(pageno_o),
		.addr_o(addr_o),
		.free_count_o(free_count_o)
	);

endmodule

`default_nettype wire

//--- test/pam_props.sv
`timescale 1ns/1ps
`default_nettype none

// Result and overflow properties on the top level ports
module pam_props
(
	input wire logic clk,
	input wire logic rst,
	input wire logic done_i,
	input wire logic ok_i,
	input wire logic overflow_i
);

	// Each command completes in a single strobe
	a_done_single: assert property (@(posedge clk) disable iff (rst) done_i |=> !done_i)
		else $error("done_o high on two consecutive cycles");

	// ok only qualifies a result
	a_ok_with_done: assert property (@(posedge clk) disable iff (rst) !done_i |-> !ok_i)
		else $error("ok_o high without done_o");

	// Overflow is sticky until reset
	a_overflow_sticky: assert property (@(posedge clk) disable iff (rst)
		$fell(overflow_i) |-> $past(rst))
		else $error("overflow_o fell without reset");

endmodule

bind pam_top pam_props u_props
(
	.clk(clk),
	.rst(rst),
	.done_i(done_o),
	.ok_i(ok_o),
	.overflow_i(overflow_o)
);

`default_nettype wire

//--- test/pam_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pam_tb;

	localparam int PAGE_BITS = 8;
	localparam int PAGE_SHIFT = 12;
	localparam int QUEUE_DEPTH = 4;
	localparam int NUM_PAGES = 256;
	localparam int RESERVED_LOW = 3;
	// All pages minus 0..2 and the last one
	localparam int MAX_FREE = NUM_PAGES - RESERVED_LOW - 1;
	localparam int NUM_RANDOM = 300;
	// Directed allocs, random mix, exhaustion, reserved frees, freeall pair, overflow burst
	localparam int NUM_CMDS = 8 + NUM_RANDOM + (MAX_FREE + 1) + 2 + 2 + 7;
	localparam int TIMEOUT = 200 * NUM_CMDS + 2000;
	localparam int CMD_ALLOC = 0;
	localparam int CMD_FREE = 1;
	localparam int CMD_FREEALL = 2;

	logic clk;
	logic rst;
	logic alloc_i;
	logic free_i;
	logic freeall_i;
	logic [PAGE_BITS-1:0] pageno_i;
	logic done_o;
	logic ok_o;
	logic [PAGE_BITS-1:0] pageno_o;
	logic [PAGE_BITS+PAGE_SHIFT-1:0] addr_o;
	logic [PAGE_BITS-1:0] free_count_o;
	logic overflow_o;

	// Reference map, set means in use
	logic used [NUM_PAGES];
	int model_free;
	// Expected results in command order
	logic exp_ok [$];
	logic [PAGE_BITS-1:0] exp_page [$];
	logic [PAGE_BITS-1:0] exp_count [$];
	logic [31:0] rng;
	int n_issued;
	int n_done;
	int n_checks;
	int n_errors;
	int cycles;

	pam_top #(
		.PAGE_BITS(PAGE_BITS),
		.PAGE_SHIFT(PAGE_SHIFT),
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) DUT (
		.clk(clk),
		.rst(rst),
		.alloc_i(alloc_i),
		.free_i(free_i),
		.freeall_i(freeall_i),
		.pageno_i(pageno_i),
		.done_o(done_o),
		.ok_o(ok_o),
		.pageno_o(pageno_o),
		.addr_o(addr_o),
		.free_count_o(free_count_o),
		.overflow_o(overflow_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ========================================
	// Helpers and reference model
	// ========================================

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		n_checks++;
		if (got !== exp)
		begin
			n_errors++;
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	function automatic void push_expect(input logic ok, input logic [PAGE_BITS-1:0] page);
		exp_ok.push_back(ok);
		exp_page.push_back(page);
		exp_count.push_back(PAGE_BITS'(model_free));
	endfunction

	// Applies one command to the reference map
	task automatic model_cmd(input int op, input logic [PAGE_BITS-1:0] page);
		int pick;
		pick = 0;
		case (op)
		CMD_ALLOC:
		begin
			// Lowest free page between the reserved ends, 0 if none
			for (int p = NUM_PAGES - 2; p >= RESERVED_LOW; p--)
				if (!used[p])
					pick = p;
			if (pick != 0)
			begin
				used[pick] = 1'b1;
				model_free--;
			end
			push_expect(pick != 0, PAGE_BITS'(pick));
		end
		CMD_FREE:
		begin
			// Reserved or already free is refused
			if (page >= RESERVED_LOW && page != NUM_PAGES - 1 && used[page])
			begin
				used[page] = 1'b0;
				model_free++;
				push_expect(1'b1, page);
			end
			else
				push_expect(1'b0, page);
		end
		default:
		begin
			foreach (used[p])
				used[p] = 1'b0;
			model_free = MAX_FREE;
			push_expect(1'b1, '0);
		end
		endcase
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic clear_strobes();
		alloc_i = 1'b0;
		free_i = 1'b0;
		freeall_i = 1'b0;
	endtask

	// Raise one strobe, a dropped command never reaches the model
	task automatic apply_cmd(input int op, input logic [PAGE_BITS-1:0] page, input bit dropped);
		alloc_i = (op == CMD_ALLOC);
		free_i = (op == CMD_FREE);
		freeall_i = (op == CMD_FREEALL);
		pageno_i = page;
		if (!dropped)
		begin
			model_cmd(op, page);
			n_issued++;
		end
	endtask

	task automatic send_cmd(input int op, input logic [PAGE_BITS-1:0] page);
		apply_cmd(op, page, 1'b0);
		next_cycle();
		clear_strobes();
	endtask

	// Keep the queue from filling
	task automatic wait_for_room();
		while (n_issued - n_done >= QUEUE_DEPTH)
			next_cycle();
	endtask

	task automatic drain();
		while (n_done < n_issued)
			next_cycle();
	endtask

	// ========================================
	// Result monitor
	// ========================================

	always @(negedge clk)
	begin
		if (!rst && done_o)
		begin
			if (exp_ok.size() == 0)
			begin
				n_errors++;
				$display("Result seen with no command outstanding at cycle %0d", cycles);
			end
			else
			begin
				check_val("ok_o", 32'(ok_o), 32'(exp_ok[0]));
				check_val("pageno_o", 32'(pageno_o), 32'(exp_page[0]));
				check_val("addr_o", 32'(addr_o), 32'(exp_page[0]) << PAGE_SHIFT);
				check_val("free_count_o", 32'(free_count_o), 32'(exp_count[0]));
				void'(exp_ok.pop_front());
				void'(exp_page.pop_front());
				void'(exp_count.pop_front());
			end
			n_done++;
		end
	end

	// Watchdog
	initial
	begin
		cycles = 0;
		while (cycles < TIMEOUT)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, %0d of %0d results seen", cycles, n_done, n_issued);
		$display("Checks: %0d, errors: %0d", n_checks, n_errors);
		$display("RESULT: FAIL");
		$finish;
	end

	// ========================================
	// Stimulus
	// ========================================

	initial
	begin
		int gap;
		rst = 1'b1;
		alloc_i = 1'b0;
		free_i = 1'b0;
		freeall_i = 1'b0;
		pageno_i = '0;
		rng = 32'h6ec1;
		n_issued = 0;
		n_done = 0;
		n_checks = 0;
		n_errors = 0;
		model_free = MAX_FREE;
		foreach (used[p])
			used[p] = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;

		// Initial sweep, count appears with no result strobe
		while (free_count_o !== PAGE_BITS'(MAX_FREE))
			next_cycle();
		repeat (10) next_cycle();
		check_val("free_count_o", 32'(free_count_o), MAX_FREE);
		check_val("overflow_o", 32'(overflow_o), 0);

		// One at a time, pages 3 upward
		for (int i = 0; i < 8; i++)
		begin
			send_cmd(CMD_ALLOC, '0);
			drain();
		end

		// Random mix at random gaps
		for (int i = 0; i < NUM_RANDOM; i++)
		begin
			rng = xorshift(rng);
			wait_for_room();
			if (!rng[2])
				send_cmd(CMD_ALLOC, '0);
			else if (rng[3])
				send_cmd(CMD_FREE, PAGE_BITS'(rng[13:8]));
			else
				send_cmd(CMD_FREE, rng[23:16]);
			gap = int'(rng[26:25]);
			repeat (gap) next_cycle();
		end
		drain();

		// Fill the map, then one alloc too many
		while (model_free > 0)
		begin
			wait_for_room();
			send_cmd(CMD_ALLOC, '0);
		end
		send_cmd(CMD_ALLOC, '0);
		drain();
		check_val("free_count_o", 32'(free_count_o), 0);

		// Reserved ends stay refused on a full map
		send_cmd(CMD_FREE, '0);
		send_cmd(CMD_FREE, PAGE_BITS'(NUM_PAGES - 1));
		drain();

		// Freeall restores the map
		send_cmd(CMD_FREEALL, '0);
		send_cmd(CMD_ALLOC, '0);
		drain();

		// Burst while the bitmap is busy, sixth strobe finds the queue full
		check_val("overflow_o", 32'(overflow_o), 0);
		apply_cmd(CMD_ALLOC, '0, 1'b0);
		next_cycle();
		apply_cmd(CMD_FREE, 8'd3, 1'b0);
		next_cycle();
		apply_cmd(CMD_ALLOC, '0, 1'b0);
		next_cycle();
		apply_cmd(CMD_FREE, 8'd100, 1'b0);
		next_cycle();
		apply_cmd(CMD_ALLOC, '0, 1'b0);
		next_cycle();
		apply_cmd(CMD_ALLOC, '0, 1'b1);
		next_cycle();
		clear_strobes();
		drain();
		check_val("overflow_o", 32'(overflow_o), 1);
		// Room for a dropped command to show up as a stray result
		repeat (20) next_cycle();
		check_val("done_o count", n_done, n_issued);
		// Dropped alloc must not have taken a page
		send_cmd(CMD_ALLOC, '0);
		drain();
		repeat (5) next_cycle();

		$display("Checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
verilog/pam_pkg.sv
verilog/pam_cmd_if.sv
verilog/pam_resp_if.sv
verilog/pam_cmd_queue.sv
verilog/pam_bitmap.sv
verilog/pam_resp.sv
verilog/pam_top.sv
test/pam_props.sv
test/pam_tb.sv

//--- Bender.yml
package:
  name: pam

sources:
  # Package and stage interfaces first
  - verilog/pam_pkg.sv
  - verilog/pam_cmd_if.sv
  - verilog/pam_resp_if.sv
  # Pipeline stages and top level
  - verilog/pam_cmd_queue.sv
  - verilog/pam_bitmap.sv
  - verilog/pam_resp.sv
  - verilog/pam_top.sv
  # Testbench
  - target: test
    files:
      - test/pam_props.sv
      - test/pam_tb.sv
